/* design/axi_burst_pkg.sv */
// AXI4 burst package holding the protocol burst limits and the AxLEN field type
package axi_burst_pkg;

  //////////////////////////////////////////////////
  // Protocol limits
  //////////////////////////////////////////////////

  // Longest INCR burst that AXI4 allows
  localparam int MAX_BURST_BEATS = 256;

  // No burst may cross a 4 KB boundary
  localparam int MAX_BURST_BYTES = 4096;

  // Width of the AxLEN field
  localparam int ARLEN_WIDTH = 8;

  //////////////////////////////////////////////////
  // Field types
  //////////////////////////////////////////////////

  // Burst length, encoded as beats minus one
  typedef logic [ARLEN_WIDTH-1:0] arlen_t;

endpackage : axi_burst_pkg

/* design/read_master_pkg.sv */
// Read master package with datapath widths, count types and derived burst geometry
package read_master_pkg;

  import axi_burst_pkg::*;

  //////////////////////////////////////////////////
  // Datapath widths
  //////////////////////////////////////////////////

  localparam int ADDR_WIDTH      = 32;
  localparam int DATA_WIDTH      = 32;
  localparam int XFER_SIZE_WIDTH = 20;

  typedef logic [ADDR_WIDTH-1:0]      addr_t;
  typedef logic [DATA_WIDTH-1:0]      data_t;
  typedef logic [XFER_SIZE_WIDTH-1:0] xfer_size_t;

  // Bytes carried by one data beat
  localparam int BEAT_BYTES     = DATA_WIDTH / 8;
  localparam int LOG_BEAT_BYTES = $clog2(BEAT_BYTES);

  // Burst length bounded by both the beat and the byte limit
  localparam int BURST_BEATS     = (MAX_BURST_BYTES / BEAT_BYTES < MAX_BURST_BEATS) ?
                                   MAX_BURST_BYTES / BEAT_BYTES : MAX_BURST_BEATS;
  localparam int LOG_BURST_BEATS = $clog2(BURST_BEATS);

  // Alignment of the start address and step between bursts
  localparam int BURST_BYTES = BEAT_BYTES * BURST_BEATS;

  // Total beats minus one, then full bursts minus one
  localparam int BEAT_COUNT_WIDTH = XFER_SIZE_WIDTH - LOG_BEAT_BYTES;
  localparam int TXN_COUNT_WIDTH  = BEAT_COUNT_WIDTH - LOG_BURST_BEATS;

  typedef logic [BEAT_COUNT_WIDTH-1:0] beat_count_t;
  typedef logic [TXN_COUNT_WIDTH-1:0]  txn_count_t;

endpackage : read_master_pkg

/* design/read_cmd_if.sv */
// Read command interface that hands a prepared request from setup to issuer and tracker
`timescale 1ns/1ps

interface read_cmd_if
  import axi_burst_pkg::*;
  import read_master_pkg::*;
();

  // One-cycle request strobe, never stalled
  logic       load;
  // Start address, already burst aligned
  addr_t      base_addr;
  // Bursts in the request minus one
  txn_count_t txn_count;
  // arlen of the last burst
  arlen_t     final_len;

  // Setup side drives every field
  modport source (output load, base_addr, txn_count, final_len);
  // Issuer and tracker only observe
  modport sink   (input load, base_addr, txn_count, final_len);

endinterface : read_cmd_if

/* design/xfer_setup.sv */
// Transfer setup that rounds the size to beats, aligns the address and splits into bursts
`timescale 1ns/1ps

module xfer_setup
  import axi_burst_pkg::*;
  import read_master_pkg::*;
(
  input  logic       aclk,
  input  logic       areset,
  input  logic       ctrl_start,
  input  addr_t      ctrl_addr_offset,
  input  xfer_size_t ctrl_xfer_size_in_bytes,
  read_cmd_if.source cmd
);

  // Address bits below one burst
  localparam addr_t ALIGN_MASK = addr_t'(BURST_BYTES - 1);

  logic        start_d1;
  logic        load_r;
  logic        size_has_tail;
  beat_count_t size_beats;
  beat_count_t total_len_r;
  addr_t       addr_r;
  addr_t       base_addr_r;
  txn_count_t  txn_count_r;
  arlen_t      final_len_r;

  // Whole beats in the size, and a flag for a partial last beat
  assign size_beats    = ctrl_xfer_size_in_bytes[XFER_SIZE_WIDTH-1:LOG_BEAT_BYTES];
  assign size_has_tail = |ctrl_xfer_size_in_bytes[LOG_BEAT_BYTES-1:0];

  // Start strobe delayed twice to form load
  always_ff @(posedge aclk) begin
    if (areset) begin
      start_d1 <= 1'b0;
      load_r   <= 1'b0;
    end else begin
      start_d1 <= ctrl_start;
      load_r   <= start_d1;
    end
  end

  // Stage one, beats minus one rounded up, address cleared to the burst boundary
  always_ff @(posedge aclk) begin
    if (ctrl_start) begin
      total_len_r <= size_has_tail ? size_beats : size_beats - 1'b1;
      addr_r      <= ctrl_addr_offset & ~ALIGN_MASK;
    end
  end

  // Stage two, upper bits count full bursts and low bits give the last arlen
  always_ff @(posedge aclk) begin
    if (start_d1) begin
      base_addr_r <= addr_r;
      txn_count_r <= total_len_r[BEAT_COUNT_WIDTH-1:LOG_BURST_BEATS];
      final_len_r <= arlen_t'(total_len_r[LOG_BURST_BEATS-1:0]);
    end
  end

  assign cmd.load      = load_r;
  assign cmd.base_addr = base_addr_r;
  assign cmd.txn_count = txn_count_r;
  assign cmd.final_len = final_len_r;

endmodule : xfer_setup

/* design/ar_issuer.sv */
// AR channel issuer that walks the bursts of a request under an outstanding-burst limit
`timescale 1ns/1ps

module ar_issuer
  import axi_burst_pkg::*;
  import read_master_pkg::*;
#(
  parameter int MAX_OUTSTANDING = 4
)
(
  input  logic     aclk,
  input  logic     areset,
  read_cmd_if.sink cmd,
  input  logic     arready,
  input  logic     burst_drained,
  output logic     arvalid,
  output addr_t    araddr,
  output arlen_t   arlen
);

  localparam int     CREDIT_WIDTH = $clog2(MAX_OUTSTANDING + 1);
  // arlen of every burst except the last
  localparam arlen_t FULL_LEN     = arlen_t'(BURST_BEATS - 1);

  logic                    ar_idle;
  logic                    arvalid_r;
  logic                    arxfer;
  logic                    final_burst;
  logic                    stall;
  txn_count_t              to_go;
  addr_t                   addr_r;
  logic [CREDIT_WIDTH-1:0] credits;

  assign arxfer      = arvalid_r & arready;
  assign final_burst = (to_go == '0);
  // No credit left, hold off the next AR
  assign stall       = (credits == '0);

  //////////////////////////////////////////////////
  // Request sequencing
  //////////////////////////////////////////////////

  // Busy from load until the last burst is accepted
  always_ff @(posedge aclk) begin
    if (areset) begin
      ar_idle <= 1'b1;
    end else if (cmd.load) begin
      ar_idle <= 1'b0;
    end else if (arxfer && final_burst) begin
      ar_idle <= 1'b1;
    end
  end

  // Bursts left to issue after the current one
  always_ff @(posedge aclk) begin
    if (areset) begin
      to_go <= '0;
    end else if (cmd.load) begin
      to_go <= cmd.txn_count;
    end else if (arxfer && !final_burst) begin
      to_go <= to_go - 1'b1;
    end
  end

  // Running burst address
  always_ff @(posedge aclk) begin
    if (cmd.load) begin
      addr_r <= cmd.base_addr;
    end else if (arxfer) begin
      addr_r <= addr_r + addr_t'(BURST_BYTES);
    end
  end

  //////////////////////////////////////////////////
  // AR handshake and credits
  //////////////////////////////////////////////////

  // Raised only with a credit in hand, held until arready
  always_ff @(posedge aclk) begin
    if (areset) begin
      arvalid_r <= 1'b0;
    end else if (!arvalid_r) begin
      arvalid_r <= !ar_idle && !stall;
    end else if (arready) begin
      arvalid_r <= 1'b0;
    end
  end

  // One credit per accepted AR, returned when the burst leaves the stream port
  always_ff @(posedge aclk) begin
    if (areset) begin
      credits <= CREDIT_WIDTH'(MAX_OUTSTANDING);
    end else begin
      case ({arxfer, burst_drained})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;
        default: credits <= credits;
      endcase
    end
  end

  assign arvalid = arvalid_r;
  assign araddr  = addr_r;
  assign arlen   = final_burst ? cmd.final_len : FULL_LEN;

endmodule : ar_issuer

/* design/r_data_fifo.sv */
// First-word-fall-through FIFO that buffers R beats together with their last flag
`timescale 1ns/1ps

module r_data_fifo
  import axi_burst_pkg::*;
  import read_master_pkg::*;
#(
  parameter int DEPTH = MAX_BURST_BEATS
)
(
  input  logic  aclk,
  input  logic  areset,
  input  logic  push,
  input  data_t push_data,
  input  logic  push_last,
  input  logic  pop,
  output logic  out_valid,
  output data_t out_data,
  output logic  out_last
);

  // Extra pointer bit tells a full memory from an empty one
  localparam int PTR_WIDTH = $clog2(DEPTH);

  typedef struct packed {
    logic  last;
    data_t data;
  } entry_t;

  entry_t               mem [DEPTH];
  entry_t               out_entry;
  logic [PTR_WIDTH:0]   wr_ptr;
  logic [PTR_WIDTH:0]   rd_ptr;
  logic                 mem_empty;
  logic                 stage_load;

  assign mem_empty  = (wr_ptr == rd_ptr);
  // Refill the output stage when it is free or being taken
  assign stage_load = !mem_empty && (!out_valid || pop);

  //////////////////////////////////////////////////
  // Storage
  //////////////////////////////////////////////////

  always_ff @(posedge aclk) begin
    if (push) begin
      mem[wr_ptr[PTR_WIDTH-1:0]] <= '{last: push_last, data: push_data};
    end
  end

  always_ff @(posedge aclk) begin
    if (areset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;
      if (stage_load) rd_ptr <= rd_ptr + 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // Output stage
  //////////////////////////////////////////////////

  // Pop without valid data leaves the stage untouched
  always_ff @(posedge aclk) begin
    if (areset) begin
      out_valid <= 1'b0;
    end else if (stage_load) begin
      out_valid <= 1'b1;
    end else if (pop) begin
      out_valid <= 1'b0;
    end
  end

  always_ff @(posedge aclk) begin
    if (stage_load) out_entry <= mem[rd_ptr[PTR_WIDTH-1:0]];
  end

  assign out_data = out_entry.data;
  assign out_last = out_entry.last;

endmodule : r_data_fifo

/* design/r_completion_tracker.sv */
// Completion tracker that counts finished R bursts and pulses done after the final rlast
`timescale 1ns/1ps

module r_completion_tracker
  import read_master_pkg::*;
(
  input  logic     aclk,
  input  logic     areset,
  read_cmd_if.sink cmd,
  input  logic     rvalid,
  input  logic     rlast,
  output logic     done
);

  txn_count_t to_go;
  logic       active;
  logic       burst_end;
  logic       final_burst;

  // Last beat of a burst accepted on R
  assign burst_end   = rvalid & rlast;
  assign final_burst = (to_go == '0);

  // Request in flight on the R channel
  always_ff @(posedge aclk) begin
    if (areset) begin
      active <= 1'b0;
    end else if (cmd.load) begin
      active <= 1'b1;
    end else if (burst_end && final_burst) begin
      active <= 1'b0;
    end
  end

  // Bursts still to complete after the current one
  always_ff @(posedge aclk) begin
    if (areset) begin
      to_go <= '0;
    end else if (cmd.load) begin
      to_go <= cmd.txn_count;
    end else if (active && burst_end && !final_burst) begin
      to_go <= to_go - 1'b1;
    end
  end

  // One-cycle pulse, the cycle after the final rlast
  always_ff @(posedge aclk) begin
    if (areset) done <= 1'b0;
    else done <= active && burst_end && final_burst;
  end

endmodule : r_completion_tracker

/* design/axi_read_master.sv */
// AXI4 read master top level joining setup, AR issue, R buffering and completion tracking
`timescale 1ns/1ps

module axi_read_master
  import axi_burst_pkg::*;
  import read_master_pkg::*;
#(
  parameter int MAX_OUTSTANDING = 4
)
(
  input  logic       aclk,
  input  logic       areset,
  // Control
  input  logic       ctrl_start,
  input  addr_t      ctrl_addr_offset,
  input  xfer_size_t ctrl_xfer_size_in_bytes,
  output logic       ctrl_done,
  // AXI4 read address and data
  output logic       m_axi_arvalid,
  input  logic       m_axi_arready,
  output addr_t      m_axi_araddr,
  output arlen_t     m_axi_arlen,
  input  logic       m_axi_rvalid,
  output logic       m_axi_rready,
  input  data_t      m_axi_rdata,
  input  logic       m_axi_rlast,
  // AXI4-Stream master
  output logic       m_axis_tvalid,
  input  logic       m_axis_tready,
  output data_t      m_axis_tdata,
  output logic       m_axis_tlast
);

  // Room for every outstanding burst, power of two
  localparam int FIFO_DEPTH = 2 ** $clog2(BURST_BEATS * MAX_OUTSTANDING);

  logic rxfer;
  logic burst_drained;

  read_cmd_if cmd_if ();

  // FIFO always has room, so R is never stalled
  assign m_axi_rready  = 1'b1;
  assign rxfer         = m_axi_rvalid & m_axi_rready;
  // Burst fully handed over on the stream side
  assign burst_drained = m_axis_tvalid & m_axis_tready & m_axis_tlast;

  xfer_setup xfer_setup_i (
    .aclk, .areset, .ctrl_start, .ctrl_addr_offset, .ctrl_xfer_size_in_bytes, .cmd(cmd_if)
  );

  ar_issuer #(.MAX_OUTSTANDING(MAX_OUTSTANDING)) ar_issuer_i (
    .aclk, .areset, .cmd(cmd_if), .arready(m_axi_arready), .burst_drained,
    .arvalid(m_axi_arvalid), .araddr(m_axi_araddr), .arlen(m_axi_arlen)
  );

  r_data_fifo #(.DEPTH(FIFO_DEPTH)) r_data_fifo_i (
    .aclk, .areset, .push(rxfer), .push_data(m_axi_rdata), .push_last(m_axi_rlast),
    .pop(m_axis_tready), .out_valid(m_axis_tvalid), .out_data(m_axis_tdata),
    .out_last(m_axis_tlast)
  );

  r_completion_tracker r_completion_tracker_i (
    .aclk, .areset, .cmd(cmd_if), .rvalid(rxfer), .rlast(m_axi_rlast), .done(ctrl_done)
  );

endmodule : axi_read_master

/* sim/axi_read_master_props.sv */
// Bound protocol properties for the AR channel handshake and the done pulse
`timescale 1ns/1ps

module axi_read_master_props
  import axi_burst_pkg::*;
  import read_master_pkg::*;
(
  input logic   aclk,
  input logic   areset,
  input logic   ctrl_done,
  input logic   m_axi_arvalid,
  input logic   m_axi_arready,
  input addr_t  m_axi_araddr,
  input arlen_t m_axi_arlen
);

  //////////////////////////////////////////////////
  // AR channel
  //////////////////////////////////////////////////

  // Request held with its address and length until accepted
  ar_hold: assert property (@(posedge aclk) disable iff (areset)
    m_axi_arvalid && !m_axi_arready |=>
      m_axi_arvalid && $stable(m_axi_araddr) && $stable(m_axi_arlen))
    else $error("arvalid dropped or address changed before arready");

  // Nothing requested straight out of reset
  ar_after_reset: assert property (@(posedge aclk) areset |=> !m_axi_arvalid)
    else $error("arvalid high in the cycle after reset");

  // Done is a single-cycle pulse
  done_pulse: assert property (@(posedge aclk) disable iff (areset) ctrl_done |=> !ctrl_done)
    else $error("ctrl_done high for two cycles in a row");

endmodule : axi_read_master_props

bind axi_read_master axi_read_master_props axi_read_master_props_i (.*);

/* sim/axi_read_master_tb.sv */
// Testbench for the AXI4 read master with a random-timing read slave and a stream checker
`timescale 1ns/1ps

module axi_read_master_tb;
  import axi_burst_pkg::*;
  import read_master_pkg::*;

  localparam int MAX_OUTSTANDING = 2;
  localparam int NUM_ROWS        = 5;

  typedef struct packed {
    addr_t      addr;
    xfer_size_t size;
    logic       bp;
  } row_t;

  // Start address, size in bytes, random tready
  localparam row_t ROWS [NUM_ROWS] = '{
    '{32'h0000_1000, 20'd100,  1'b0},
    '{32'h0000_2345, 20'd200,  1'b0},
    '{32'h0000_4000, 20'd3000, 1'b0},
    '{32'h0000_8000, 20'd3000, 1'b1},
    '{32'h0000_c0f0, 20'd1030, 1'b1}
  };

  logic       aclk = 1'b0;
  logic       areset = 1'b1;
  logic       ctrl_start = 1'b0;
  addr_t      ctrl_addr_offset = '0;
  xfer_size_t ctrl_xfer_size_in_bytes = '0;
  logic       ctrl_done;
  logic       m_axi_arvalid;
  logic       m_axi_arready = 1'b0;
  addr_t      m_axi_araddr;
  arlen_t     m_axi_arlen;
  logic       m_axi_rvalid = 1'b0;
  logic       m_axi_rready;
  data_t      m_axi_rdata = '0;
  logic       m_axi_rlast = 1'b0;
  logic       m_axis_tvalid;
  logic       m_axis_tready = 1'b0;
  data_t      m_axis_tdata;
  logic       m_axis_tlast;

  // Expected AR bursts and stream beats of the current row
  addr_t  exp_addr_q [$];
  arlen_t exp_len_q [$];
  data_t  exp_data_q [$];
  logic   exp_last_q [$];
  // Slave side burst queue and current burst
  addr_t  r_addr_q [$];
  int     r_beats_q [$];
  addr_t  r_addr;
  int     r_left;
  data_t  exp_d;
  logic   exp_l;

  int ar_count = 0;
  int tlast_count = 0;
  int rlast_total = 0;
  int rlast_target = 0;
  int done_total = 0;
  int err_count = 0;
  int row_beats = 0;
  int row_bursts = 0;
  int cycle_limit = 0;
  int cycles = 0;
  logic row_bp = 1'b0;

  axi_read_master #(.MAX_OUTSTANDING(MAX_OUTSTANDING)) axi_read_master_i (.*);

  always #10 aclk = ~aclk;

  // Whole beats needed for a byte count
  function automatic int beats_of(input xfer_size_t size);
    return (int'(size) + BEAT_BYTES - 1) / BEAT_BYTES;
  endfunction

  // Expected bursts and beats from a base aligned down to a burst boundary
  task automatic build_expected(input addr_t addr, input xfer_size_t size);
    addr_t base;
    int    i;
    int    left;
    int    n;
    base = addr & ~addr_t'(BURST_BYTES - 1);
    row_beats = beats_of(size);
    for (i = 0; i < row_beats; i++) begin
      exp_data_q.push_back(base + addr_t'(i * BEAT_BYTES));
      exp_last_q.push_back((i % BURST_BEATS == BURST_BEATS - 1) || (i == row_beats - 1));
    end
    left = row_beats;
    row_bursts = 0;
    while (left > 0) begin
      n = (left > BURST_BEATS) ? BURST_BEATS : left;
      exp_addr_q.push_back(base + addr_t'(row_bursts * BURST_BYTES));
      exp_len_q.push_back(arlen_t'(n - 1));
      left = left - n;
      row_bursts++;
    end
  endtask

  //////////////////////////////////////////////////
  // Read slave model and stream checker
  //////////////////////////////////////////////////

  always @(posedge aclk) begin
    if (areset) begin
      r_left = 0;
    end else begin
      // Check each accepted AR and queue its burst
      if (m_axi_arvalid && m_axi_arready) begin
        ar_count++;
        if (exp_addr_q.size() == 0) begin
          $display("AR handshake at %0t ns with no burst left to expect", $time);
          err_count++;
        end else begin
          assert (m_axi_araddr == exp_addr_q[0]) else begin
            $display("FAILED at %0t ns: m_axi_araddr got %h expected %h",
                     $time, m_axi_araddr, exp_addr_q[0]);
            err_count++;
          end
          assert (m_axi_arlen == exp_len_q[0]) else begin
            $display("FAILED at %0t ns: m_axi_arlen got %0d expected %0d",
                     $time, m_axi_arlen, exp_len_q[0]);
            err_count++;
          end
          void'(exp_addr_q.pop_front());
          void'(exp_len_q.pop_front());
        end
        assert (ar_count - tlast_count <= MAX_OUTSTANDING) else begin
          $display("More than %0d bursts outstanding at %0t ns", MAX_OUTSTANDING, $time);
          err_count++;
        end
        r_addr_q.push_back(m_axi_araddr);
        r_beats_q.push_back(int'(m_axi_arlen) + 1);
      end
      // Every offered beat must meet rready high
      if (m_axi_rvalid) begin
        assert (m_axi_rready == 1'b1) else begin
          $display("FAILED at %0t ns: m_axi_rready got %b expected %b",
                   $time, m_axi_rready, 1'b1);
          err_count++;
        end
        if (m_axi_rlast) rlast_total++;
        r_addr = r_addr + addr_t'(BEAT_BYTES);
        r_left--;
      end
      if (r_left == 0 && r_addr_q.size() != 0) begin
        r_addr = r_addr_q.pop_front();
        r_left = r_beats_q.pop_front();
      end
      // Beat data is its own byte address
      m_axi_rvalid <= (r_left != 0) && ($urandom_range(3) != 0);
      m_axi_rdata  <= r_addr;
      m_axi_rlast  <= (r_left == 1);
      m_axi_arready <= ($urandom_range(1) == 1);
      // Stream beat taken
      if (m_axis_tvalid && m_axis_tready) begin
        if (m_axis_tlast) tlast_count++;
        if (exp_data_q.size() == 0) begin
          $display("Stream beat at %0t ns with no beat left to expect", $time);
          err_count++;
        end else begin
          exp_d = exp_data_q.pop_front();
          exp_l = exp_last_q.pop_front();
          assert (m_axis_tdata == exp_d) else begin
            $display("FAILED at %0t ns: m_axis_tdata got %h expected %h",
                     $time, m_axis_tdata, exp_d);
            err_count++;
          end
          assert (m_axis_tlast == exp_l) else begin
            $display("FAILED at %0t ns: m_axis_tlast got %b expected %b",
                     $time, m_axis_tlast, exp_l);
            err_count++;
          end
        end
      end
      m_axis_tready <= row_bp ? ($urandom_range(2) == 0) : 1'b1;
      // Done only after the final rlast of the row
      if (ctrl_done) begin
        done_total++;
        assert (rlast_total == rlast_target) else begin
          $display("FAILED at %0t ns: rlast count at ctrl_done got %0d expected %0d",
                   $time, rlast_total, rlast_target);
          err_count++;
        end
      end
    end
  end

  // Run limit from the table length
  always @(posedge aclk) begin
    cycles <= cycles + 1;
    if (cycle_limit != 0 && cycles >= cycle_limit) begin
      $display("Timeout after %0d cycles with rows still running", cycles);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // Row sequencing
  //////////////////////////////////////////////////

  initial begin
    int r;
    int total_beats;
    int done_base;
    int err_base;
    int row_err;
    int check_errors;
    int rows_passed;
    void'($urandom(32'hb6946164));
    total_beats = 0;
    check_errors = 0;
    rows_passed = 0;
    for (r = 0; r < NUM_ROWS; r++) total_beats += beats_of(ROWS[r].size);
    cycle_limit = 8 * total_beats + 2000;
    repeat (16) @(posedge aclk);
    areset <= 1'b0;
    for (r = 0; r < NUM_ROWS; r++) begin
      build_expected(ROWS[r].addr, ROWS[r].size);
      rlast_target = rlast_target + row_bursts;
      row_bp = ROWS[r].bp;
      done_base = done_total;
      err_base = err_count + check_errors;
      @(posedge aclk);
      ctrl_start              <= 1'b1;
      ctrl_addr_offset        <= ROWS[r].addr;
      ctrl_xfer_size_in_bytes <= ROWS[r].size;
      @(posedge aclk);
      ctrl_start <= 1'b0;
      // Row ends with its last stream beat and its done pulse
      while (exp_data_q.size() != 0 || done_total == done_base) @(posedge aclk);
      repeat (4) @(posedge aclk);
      assert (done_total - done_base == 1) else begin
        $display("FAILED at %0t ns: ctrl_done pulses got %0d expected 1",
                 $time, done_total - done_base);
        check_errors++;
      end
      row_err = err_count + check_errors - err_base;
      if (row_err == 0) rows_passed++;
      $display("Row %0d at %h, %0d bytes, %0d beats in %0d bursts: %s",
               r, ROWS[r].addr, ROWS[r].size, row_beats, row_bursts,
               (row_err == 0) ? "passed" : "failed");
    end
    $display("Rows passed %0d of %0d, errors %0d",
             rows_passed, NUM_ROWS, err_count + check_errors);
    if (err_count + check_errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule : axi_read_master_tb

/* filelist.f */
design/axi_burst_pkg.sv
design/read_master_pkg.sv
design/read_cmd_if.sv
design/xfer_setup.sv
design/ar_issuer.sv
design/r_data_fifo.sv
design/r_completion_tracker.sv
design/axi_read_master.sv
sim/axi_read_master_props.sv
sim/axi_read_master_tb.sv

/* Makefile */
# Verilator build and run of the AXI4 read master testbench

TB_TOP := axi_read_master_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f filelist.f --top-module $(TB_TOP) -o $(TB_TOP)
	@out="$$(./obj_dir/$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST RESULT: PASS"

clean:
	rm -rf obj_dir
